// File: sim/core_l2_port_patterns.txt
# op strand addr data mask load_strand load_addr cache_data expected_load_data (hex)
# op: I imiss, D dmiss, S store, R store then rolled back store, F forward, A arbitration
I 0 00001234 0 0 0 0 0 0
I 3 8000fff8 0 0 0 0 0 0
D 1 0000a0c4 0 0 0 0 0 0
D 2 7fff0010 0 0 0 0 0 0
S 0 00002000 00112233445566778899aabbccddeeff ffff 0 0 0 0
S 3 00002f1c 0123456789abcdeffedcba9876543210 0f0f 0 0 0 0
R 1 00003000 deadbeefcafef00d1234567887654321 00ff 0 0 0 0
R 2 00003010 1111111122222222333333334444444 f000 0 0 0 0
F 1 00001230 112233445566778899aabbccddeeff00 00ff 1 00001230 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 a5a5a5a5a5a5a5a599aabbccddeeff00
F 1 00001230 112233445566778899aabbccddeeff00 00ff 2 00001230 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
F 1 00001230 112233445566778899aabbccddeeff00 00ff 1 00001240 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
F 0 00004560 112233445566778899aabbccddeeff00 f00f 0 0000456c 0123456789abcdeffedcba9876543210 1122334489abcdeffedcba98ddeeff00
F 3 00004560 112233445566778899aabbccddeeff00 f00f 2 0000456c 0123456789abcdeffedcba9876543210 0123456789abcdeffedcba9876543210
A 0 00005000 cafecafecafecafecafecafecafecafe 0ff0 0 0 0 0
A 1 00006000 0badf00d0badf00d0badf00d0badf00d ffff 0 0 0 0
A 2 00007000 13579bdf2468ace013579bdf2468ace0 8001 0 0 0 0
I 2 0000beef 0 0 0 0 0 0
A 3 00008000 fedcba9876543210fedcba9876543210 00f0 0 0 0 0

// File: core_l2_port.f
hw/core_pkg.sv
hw/l2_pkg.sv
hw/l1_miss_queue.sv
hw/store_buffer.sv
hw/l2_arbiter_mux.sv
hw/core_l2_port.sv
sim/core_l2_port_assertions.sv
sim/core_l2_port_tb.sv

// File: Makefile
# Verilator build and run for the core L2 port testbench

VERILATOR ?= verilator
TOP ?= core_l2_port_tb
FILELIST ?= core_l2_port.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/core_l2_port_tb.sv
`timescale 1ns/1ns
/*
 * Pattern driven testbench with a simple L2 model.
 * Patterns are read from sim/core_l2_port_patterns.txt, run from the project root.
 */

module core_l2_port_tb;

	import core_pkg::*;
	import l2_pkg::*;

	logic clk;
	logic rst_n_i;
	miss_req_t imiss_i;
	miss_req_t dmiss_i;
	store_req_t store_i;
	l1_addr_u load_addr_i;
	strand_t load_strand_i;
	line_data_t cache_data_i;
	line_data_t load_data_o;
	logic [NUM_STRANDS-1:0] i_load_complete_o;
	logic [NUM_STRANDS-1:0] d_load_complete_o;
	logic [NUM_STRANDS-1:0] store_resume_o;
	logic rollback_o;
	l2_req_t pci_o;
	logic pci_ack_i;
	l2_resp_t cpi_i;

	logic hold_l2;
	logic mon_en;
	int errors;
	int cycle;
	int ack_wait;
	int rr_model;
	int watchdog_cycles;
	int i_cnt;
	int d_cnt;
	int s_cnt;
	logic have_snap;
	l2_req_t snap;
	l2_req_t acked [$];
	l2_resp_t resp_q [$];
	int resp_due [$];
	l2_resp_t prev_cpi;
	logic [NUM_STRANDS-1:0] exp_i;
	logic [NUM_STRANDS-1:0] exp_d;
	logic [NUM_STRANDS-1:0] exp_s;

	// Pattern columns
	logic [7:0] p_op [$];
	logic [1:0] p_strand [$];
	logic [31:0] p_addr [$];
	logic [127:0] p_data [$];
	logic [15:0] p_mask [$];
	logic [1:0] p_lstrand [$];
	logic [31:0] p_laddr [$];
	logic [127:0] p_cache [$];
	logic [127:0] p_expect [$];

	core_l2_port u_core_l2_port (.*);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic check_value(input string what, input logic [255:0] got,
			input logic [255:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "check failed");
		end
	endtask

	task automatic take_request(output l2_req_t req);
		if (acked.size() == 0) begin
			$display("No L2 request was acknowledged for this operation");
			$display("RESULT: FAIL");
			$fatal(1, "missing request");
		end
		req = acked.pop_front();
	endtask

	task automatic check_req(input l2_req_t req, input int unit, input logic [1:0] strand,
			input logic [2:0] op, input logic [31:0] addr, input logic [127:0] data,
			input logic [15:0] mask);
		check_value("request unit", req.unit, unit);
		check_value("request strand", req.strand, strand);
		check_value("request op", req.op, op);
		check_value("request line address", req.address, addr[31:4]);
		check_value("request data", req.data, data);
		check_value("request mask", req.mask, mask);
	endtask

	// L2 model: random acknowledge delay, responses in acknowledge order
	initial begin
		l2_resp_t r;
		pci_ack_i = 1'b0;
		cpi_i = '0;
		void'($urandom(18));
		forever begin
			@(posedge clk);
			if (!rst_n_i) begin
				pci_ack_i <= 1'b0;
				cpi_i <= '0;
				have_snap = 1'b0;
				ack_wait = 0;
			end else begin
				cycle++;
				if (resp_q.size() > 0 && cycle >= resp_due[0]) begin
					r = resp_q.pop_front();
					void'(resp_due.pop_front());
					cpi_i <= r;
				end else begin
					cpi_i <= '0;
				end
				if (pci_ack_i) begin
					check_value("request held at acknowledge", pci_o, snap);
					acked.push_back(pci_o);
					rr_model = (int'(pci_o.unit) + 1) % 3;
					r = '0;
					r.valid = 1'b1;
					r.unit = pci_o.unit;
					r.strand = pci_o.strand;
					r.data = {4{32'h5a5a0000 | 32'(pci_o.address[15:0])}};
					resp_q.push_back(r);
					resp_due.push_back(cycle + 2 + int'($urandom % 3));
					pci_ack_i <= 1'b0;
					have_snap = 1'b0;
					ack_wait = int'($urandom % 4);
				end else if (pci_o.valid) begin
					if (!have_snap) begin
						snap = pci_o;
						have_snap = 1'b1;
					end else begin
						check_value("request held while waiting", pci_o, snap);
					end
					if (!hold_l2) begin
						if (ack_wait == 0)
							pci_ack_i <= 1'b1;
						else
							ack_wait--;
					end
				end
			end
		end
	end

	// Each completion pulse must follow its response by one cycle
	always @(posedge clk) begin
		if (mon_en) begin
			exp_i = '0;
			exp_d = '0;
			exp_s = '0;
			if (prev_cpi.valid && prev_cpi.unit == UNIT_ICACHE) exp_i[prev_cpi.strand] = 1'b1;
			if (prev_cpi.valid && prev_cpi.unit == UNIT_DCACHE) exp_d[prev_cpi.strand] = 1'b1;
			if (prev_cpi.valid && prev_cpi.unit == UNIT_STBUF) exp_s[prev_cpi.strand] = 1'b1;
			check_value("icache load complete", i_load_complete_o, exp_i);
			check_value("dcache load complete", d_load_complete_o, exp_d);
			check_value("store resume", store_resume_o, exp_s);
			if (i_load_complete_o != '0) i_cnt++;
			if (d_load_complete_o != '0) d_cnt++;
			if (store_resume_o != '0) s_cnt++;
		end
		prev_cpi = cpi_i;
	end

	task automatic run_miss(input logic is_d, input logic [1:0] strand, input logic [31:0] addr);
		l2_req_t req;
		int c0;
		c0 = is_d ? d_cnt : i_cnt;
		@(posedge clk);
		if (is_d) dmiss_i <= '{valid: 1'b1, strand: strand, addr: addr};
		else imiss_i <= '{valid: 1'b1, strand: strand, addr: addr};
		@(posedge clk);
		imiss_i.valid <= 1'b0;
		dmiss_i.valid <= 1'b0;
		while ((is_d ? d_cnt : i_cnt) == c0) @(posedge clk);
		take_request(req);
		check_req(req, is_d ? 1 : 0, strand, OP_LOAD, addr, '0, '0);
		check_value("extra requests", acked.size(), 0);
	endtask

	task automatic run_store(input logic rollback, input logic [1:0] strand,
			input logic [31:0] addr, input logic [127:0] data, input logic [15:0] mask);
		l2_req_t req;
		int c0;
		c0 = s_cnt;
		@(posedge clk);
		store_i <= '{valid: 1'b1, strand: strand, addr: addr, data: data, mask: mask};
		@(posedge clk);
		if (rollback) begin
			store_i.data <= ~data;
			@(posedge clk);
			check_value("rollback on accepted store", rollback_o, 1'b0);
		end
		store_i.valid <= 1'b0;
		@(posedge clk);
		check_value("rollback pulse", rollback_o, rollback);
		while (s_cnt == c0) @(posedge clk);
		take_request(req);
		check_req(req, 2, strand, OP_STORE, addr, data, mask);
		check_value("extra requests", acked.size(), 0);
	endtask

	task automatic run_forward(input int k);
		l2_req_t req;
		int c0;
		c0 = s_cnt;
		@(posedge clk);
		hold_l2 <= 1'b1;
		store_i <= '{valid: 1'b1, strand: p_strand[k], addr: p_addr[k], data: p_data[k],
			mask: p_mask[k]};
		@(posedge clk);
		store_i.valid <= 1'b0;
		load_strand_i <= p_lstrand[k];
		load_addr_i <= p_laddr[k];
		cache_data_i <= p_cache[k];
		@(posedge clk);
		check_value("forwarded load data", load_data_o, p_expect[k]);
		hold_l2 <= 1'b0;
		while (s_cnt == c0) @(posedge clk);
		take_request(req);
		check_req(req, 2, p_strand[k], OP_STORE, p_addr[k], p_data[k], p_mask[k]);
	endtask

	task automatic run_arbitration(input int k);
		l2_req_t req;
		int p;
		int ci;
		int cd;
		int cs;
		int unit;
		p = rr_model;
		ci = i_cnt;
		cd = d_cnt;
		cs = s_cnt;
		@(posedge clk);
		hold_l2 <= 1'b1;
		imiss_i <= '{valid: 1'b1, strand: p_strand[k], addr: p_addr[k]};
		dmiss_i <= '{valid: 1'b1, strand: p_strand[k], addr: p_addr[k] + 32'd16};
		store_i <= '{valid: 1'b1, strand: p_strand[k], addr: p_addr[k] + 32'd32,
			data: p_data[k], mask: p_mask[k]};
		@(posedge clk);
		imiss_i.valid <= 1'b0;
		dmiss_i.valid <= 1'b0;
		store_i.valid <= 1'b0;
		repeat (3) @(posedge clk);
		hold_l2 <= 1'b0;
		while (i_cnt == ci || d_cnt == cd || s_cnt == cs) @(posedge clk);
		for (int n = 0; n < 3; n++) begin
			unit = (p + n) % 3;
			take_request(req);
			if (unit == 2)
				check_req(req, 2, p_strand[k], OP_STORE, p_addr[k] + 32'd32, p_data[k],
					p_mask[k]);
			else
				check_req(req, unit, p_strand[k], OP_LOAD, p_addr[k] + 32'(unit * 16), '0, '0);
		end
	endtask

	initial begin
		int fd;
		string line;
		logic [7:0] op;
		logic [1:0] st;
		logic [1:0] ls;
		logic [31:0] ad;
		logic [31:0] la;
		logic [127:0] da;
		logic [127:0] ca;
		logic [127:0] ex;
		logic [15:0] mk;
		rst_n_i = 1'b0;
		imiss_i = '0;
		dmiss_i = '0;
		store_i = '0;
		load_addr_i = '0;
		load_strand_i = '0;
		cache_data_i = '0;
		hold_l2 = 1'b0;
		mon_en = 1'b0;
		errors = 0;
		cycle = 0;
		rr_model = 0;
		watchdog_cycles = 0;
		fd = $fopen("sim/core_l2_port_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open the pattern file sim/core_l2_port_patterns.txt");
			$display("RESULT: FAIL");
			$fatal(1, "no patterns");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line.getc(0) != "#") begin
				if ($sscanf(line, "%c %h %h %h %h %h %h %h %h", op, st, ad, da, mk, ls, la,
						ca, ex) == 9) begin
					p_op.push_back(op);
					p_strand.push_back(st);
					p_addr.push_back(ad);
					p_data.push_back(da);
					p_mask.push_back(mk);
					p_lstrand.push_back(ls);
					p_laddr.push_back(la);
					p_cache.push_back(ca);
					p_expect.push_back(ex);
				end
			end
		end
		$fclose(fd);
		watchdog_cycles = p_op.size() * 200 + 100;

		repeat (16) @(posedge clk);
		rst_n_i <= 1'b1;
		mon_en <= 1'b1;
		// Idle port after reset
		repeat (6) begin
			@(posedge clk);
			check_value("request valid after reset", pci_o.valid, 1'b0);
			check_value("rollback after reset", rollback_o, 1'b0);
		end

		foreach (p_op[k]) begin
			case (p_op[k])
				"I": run_miss(1'b0, p_strand[k], p_addr[k]);
				"D": run_miss(1'b1, p_strand[k], p_addr[k]);
				"S": run_store(1'b0, p_strand[k], p_addr[k], p_data[k], p_mask[k]);
				"R": run_store(1'b1, p_strand[k], p_addr[k], p_data[k], p_mask[k]);
				"F": run_forward(k);
				"A": run_arbitration(k);
				default: check_value("pattern op code", p_op[k], "?");
			endcase
		end
		repeat (10) @(posedge clk);

		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles + 16) @(posedge clk);
		$display("Timeout: the patterns did not finish within %0d cycles", watchdog_cycles);
		$display("RESULT: FAIL");
		$fatal(1, "timeout");
	end

endmodule

// File: sim/core_l2_port_assertions.sv
`timescale 1ns/1ns
/*
 * Protocol checks on the L2 request port and the per-strand entries.
 * The pipeline rules (no miss on a pending strand) are checked here too.
 */

module core_l2_port_assertions (
	input logic                             clk,
	input logic                             rst_n_i,
	input l2_pkg::l2_req_t                  pci_o,
	input logic                             pci_ack_i,
	input core_pkg::miss_req_t              imiss_i,
	input core_pkg::miss_req_t              dmiss_i,
	input logic [core_pkg::NUM_STRANDS-1:0] i_pending_i,
	input logic [core_pkg::NUM_STRANDS-1:0] d_pending_i,
	input logic [core_pkg::NUM_STRANDS-1:0] store_resume_o,
	input logic [core_pkg::NUM_STRANDS-1:0] sb_valid_i
);

	// A waiting request keeps its value until acknowledged
	a_req_held: assert property (@(posedge clk) disable iff (!rst_n_i)
		pci_o.valid && !pci_ack_i |=> pci_o.valid && $stable(pci_o))
		else $error("L2 request changed before its acknowledge");

	a_imiss_free: assert property (@(posedge clk) disable iff (!rst_n_i)
		imiss_i.valid |-> !i_pending_i[imiss_i.strand])
		else $error("Instruction miss on a strand that is still pending");

	a_dmiss_free: assert property (@(posedge clk) disable iff (!rst_n_i)
		dmiss_i.valid |-> !d_pending_i[dmiss_i.strand])
		else $error("Data miss on a strand that is still pending");

	// Resume only for a strand that held a store
	a_resume_entry: assert property (@(posedge clk) disable iff (!rst_n_i)
		|store_resume_o |-> (($past(sb_valid_i) & store_resume_o) != '0))
		else $error("Store resume without a pending entry");

endmodule

bind core_l2_port core_l2_port_assertions u_assertions (
	.clk(clk),
	.rst_n_i(rst_n_i),
	.pci_o(pci_o),
	.pci_ack_i(pci_ack_i),
	.imiss_i(imiss_i),
	.dmiss_i(dmiss_i),
	.i_pending_i(u_icache_miss.pending_q),
	.d_pending_i(u_dcache_miss.pending_q),
	.store_resume_o(store_resume_o),
	.sb_valid_i(u_store_buffer.entry_valid_q)
);

// File: hw/core_l2_port.sv
`timescale 1ns/1ns
/*
 * Memory side of a four-strand core: two miss queues, a store buffer
 * and the arbiter onto the single L2 request port.
 * The pipeline and the L1 arrays sit outside, behind these ports.
 */

module core_l2_port (
	input  logic                             clk,
	input  logic                             rst_n_i,
	input  core_pkg::miss_req_t              imiss_i,
	input  core_pkg::miss_req_t              dmiss_i,
	input  core_pkg::store_req_t             store_i,
	input  core_pkg::l1_addr_u               load_addr_i,
	input  core_pkg::strand_t                load_strand_i,
	input  core_pkg::line_data_t             cache_data_i,
	output core_pkg::line_data_t             load_data_o,
	output logic [core_pkg::NUM_STRANDS-1:0] i_load_complete_o,
	output logic [core_pkg::NUM_STRANDS-1:0] d_load_complete_o,
	output logic [core_pkg::NUM_STRANDS-1:0] store_resume_o,
	output logic                             rollback_o,
	output l2_pkg::l2_req_t                  pci_o,
	input  logic                             pci_ack_i,
	input  l2_pkg::l2_resp_t                 cpi_i
);

	import l2_pkg::*;

	l2_req_t icache_req;
	l2_req_t dcache_req;
	l2_req_t stbuf_req;
	logic icache_ack;
	logic dcache_ack;
	logic stbuf_ack;

	l1_miss_queue #(
		.UNIT_ID(UNIT_ICACHE)
	) u_icache_miss (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.miss_i(imiss_i),
		.cpi_i(cpi_i),
		.pci_ack_i(icache_ack),
		.pci_o(icache_req),
		.load_complete_o(i_load_complete_o)
	);

	l1_miss_queue #(
		.UNIT_ID(UNIT_DCACHE)
	) u_dcache_miss (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.miss_i(dmiss_i),
		.cpi_i(cpi_i),
		.pci_ack_i(dcache_ack),
		.pci_o(dcache_req),
		.load_complete_o(d_load_complete_o)
	);

	store_buffer u_store_buffer (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.store_i(store_i),
		.load_addr_i(load_addr_i),
		.load_strand_i(load_strand_i),
		.cache_data_i(cache_data_i),
		.cpi_i(cpi_i),
		.pci_ack_i(stbuf_ack),
		.pci_o(stbuf_req),
		.load_data_o(load_data_o),
		.store_resume_o(store_resume_o),
		.rollback_o(rollback_o)
	);

	l2_arbiter_mux u_l2_arbiter (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.icache_req_i(icache_req),
		.dcache_req_i(dcache_req),
		.stbuf_req_i(stbuf_req),
		.pci_ack_i(pci_ack_i),
		.pci_o(pci_o),
		.icache_ack_o(icache_ack),
		.dcache_ack_o(dcache_ack),
		.stbuf_ack_o(stbuf_ack)
	);

endmodule

// File: hw/l2_arbiter_mux.sv
`timescale 1ns/1ns
/*
 * Round-robin choice among the icache, dcache and store buffer requests.
 * The grant is combinational and locked until pci_ack_i.
 * Requesters must hold their request unchanged until acknowledged.
 */

module l2_arbiter_mux (
	input  logic            clk,
	input  logic            rst_n_i,
	input  l2_pkg::l2_req_t icache_req_i,
	input  l2_pkg::l2_req_t dcache_req_i,
	input  l2_pkg::l2_req_t stbuf_req_i,
	input  logic            pci_ack_i,
	output l2_pkg::l2_req_t pci_o,
	output logic            icache_ack_o,
	output logic            dcache_ack_o,
	output logic            stbuf_ack_o
);

	import l2_pkg::*;

	// Indexed by unit code
	l2_req_t reqs [NUM_REQUESTERS];
	logic [1:0] rr_ptr_q;
	logic locked_q;
	logic [1:0] lock_sel_q;
	logic [1:0] sel;
	logic grant;
	int cand;

	assign reqs[UNIT_ICACHE] = icache_req_i;
	assign reqs[UNIT_DCACHE] = dcache_req_i;
	assign reqs[UNIT_STBUF] = stbuf_req_i;

	always_comb begin
		sel = lock_sel_q;
		grant = locked_q;
		cand = 0;
		if (!locked_q) begin
			// Walk backwards so the requester nearest the pointer wins
			for (int i = NUM_REQUESTERS - 1; i >= 0; i--) begin
				cand = (int'(rr_ptr_q) + i) % NUM_REQUESTERS;
				if (reqs[cand].valid) begin
					sel = 2'(cand);
					grant = 1'b1;
				end
			end
		end
	end

	assign pci_o = grant ? reqs[sel] : '0;

	assign icache_ack_o = pci_ack_i && grant && (sel == 2'(UNIT_ICACHE));
	assign dcache_ack_o = pci_ack_i && grant && (sel == 2'(UNIT_DCACHE));
	assign stbuf_ack_o = pci_ack_i && grant && (sel == 2'(UNIT_STBUF));

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rr_ptr_q <= '0;
			locked_q <= 1'b0;
			lock_sel_q <= '0;
		end else if (grant && pci_ack_i) begin
			locked_q <= 1'b0;
			rr_ptr_q <= (sel == 2'(NUM_REQUESTERS - 1)) ? 2'd0 : sel + 2'd1;
		end else if (grant) begin
			locked_q <= 1'b1;
			lock_sel_q <= sel;
		end
	end

endmodule

// File: hw/store_buffer.sv
`timescale 1ns/1ns
/*
 * One store line per strand, held until L2 confirms the write.
 * A store to a strand whose entry is occupied is dropped and rolled back.
 * Loads from the same strand and line see the pending bytes merged in.
 */

module store_buffer (
	input  logic                             clk,
	input  logic                             rst_n_i,
	input  core_pkg::store_req_t             store_i,
	input  core_pkg::l1_addr_u               load_addr_i,
	input  core_pkg::strand_t                load_strand_i,
	input  core_pkg::line_data_t             cache_data_i,
	input  l2_pkg::l2_resp_t                 cpi_i,
	input  logic                             pci_ack_i,
	output l2_pkg::l2_req_t                  pci_o,
	output core_pkg::line_data_t             load_data_o,
	output logic [core_pkg::NUM_STRANDS-1:0] store_resume_o,
	output logic                             rollback_o
);

	import core_pkg::*;
	import l2_pkg::*;

	logic [NUM_STRANDS-1:0] entry_valid_q;
	logic [NUM_STRANDS-1:0] issued_q;
	l1_addr_u addr_q [NUM_STRANDS];
	line_data_t data_q [NUM_STRANDS];
	line_mask_t mask_q [NUM_STRANDS];
	logic hold_q;
	strand_t hold_strand_q;
	logic [NUM_STRANDS-1:0] waiting;
	strand_t first_waiting;
	strand_t sel_strand;
	logic store_accept;
	logic resp_hit;
	logic fwd_hit;

	assign waiting = entry_valid_q & ~issued_q;
	assign store_accept = store_i.valid && !entry_valid_q[store_i.strand];
	assign resp_hit = cpi_i.valid && (cpi_i.unit == UNIT_STBUF);

	always_comb begin
		first_waiting = '0;
		for (int s = NUM_STRANDS - 1; s >= 0; s--) begin
			if (waiting[s]) begin
				first_waiting = strand_t'(s);
			end
		end
	end

	assign sel_strand = hold_q ? hold_strand_q : first_waiting;

	always_comb begin
		pci_o = '0;
		pci_o.valid = |waiting;
		pci_o.unit = UNIT_STBUF;
		pci_o.strand = sel_strand;
		pci_o.op = OP_STORE;
		pci_o.address = addr_q[sel_strand].ln.line;
		pci_o.data = data_q[sel_strand];
		pci_o.mask = mask_q[sel_strand];
	end

	// Only the loading strand's own entry is visible to it
	assign fwd_hit = entry_valid_q[load_strand_i]
		&& (addr_q[load_strand_i].tso.tag == load_addr_i.tso.tag)
		&& (addr_q[load_strand_i].tso.set == load_addr_i.tso.set);

	always_comb begin
		load_data_o = cache_data_i;
		for (int b = 0; b < LINE_BYTES; b++) begin
			if (fwd_hit && mask_q[load_strand_i][b]) begin
				load_data_o[b*8 +: 8] = data_q[load_strand_i][b*8 +: 8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (store_accept) begin
			addr_q[store_i.strand] <= store_i.addr;
			data_q[store_i.strand] <= store_i.data;
			mask_q[store_i.strand] <= store_i.mask;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			entry_valid_q <= '0;
			issued_q <= '0;
			hold_q <= 1'b0;
			hold_strand_q <= '0;
			store_resume_o <= '0;
			rollback_o <= 1'b0;
		end else begin
			store_resume_o <= '0;
			rollback_o <= store_i.valid && !store_accept;

			if (pci_o.valid && pci_ack_i) begin
				issued_q[sel_strand] <= 1'b1;
				hold_q <= 1'b0;
			end else if (pci_o.valid) begin
				hold_q <= 1'b1;
				hold_strand_q <= sel_strand;
			end

			// Entry frees on the same edge the resume pulse starts
			if (resp_hit) begin
				entry_valid_q[cpi_i.strand] <= 1'b0;
				issued_q[cpi_i.strand] <= 1'b0;
				store_resume_o[cpi_i.strand] <= 1'b1;
			end

			if (store_accept) begin
				entry_valid_q[store_i.strand] <= 1'b1;
				issued_q[store_i.strand] <= 1'b0;
			end
		end
	end

endmodule

// File: hw/l1_miss_queue.sv
`timescale 1ns/1ns
/*
 * One pending miss per strand, issued to L2 as a line load.
 * The pipeline must not raise a miss on a strand that is still pending.
 * Lowest waiting strand goes first; an unacknowledged request is held.
 */

module l1_miss_queue #(
	parameter l2_pkg::l2_unit_t UNIT_ID = l2_pkg::UNIT_ICACHE
) (
	input  logic                            clk,
	input  logic                            rst_n_i,
	input  core_pkg::miss_req_t             miss_i,
	input  l2_pkg::l2_resp_t                cpi_i,
	input  logic                            pci_ack_i,
	output l2_pkg::l2_req_t                 pci_o,
	output logic [core_pkg::NUM_STRANDS-1:0] load_complete_o
);

	import core_pkg::*;
	import l2_pkg::*;

	logic [NUM_STRANDS-1:0] pending_q;
	logic [NUM_STRANDS-1:0] issued_q;
	logic [LINE_ADDR_W-1:0] line_q [NUM_STRANDS];
	logic hold_q;
	strand_t hold_strand_q;
	logic [NUM_STRANDS-1:0] waiting;
	strand_t first_waiting;
	strand_t sel_strand;
	logic resp_hit;

	assign waiting = pending_q & ~issued_q;

	always_comb begin
		first_waiting = '0;
		for (int s = NUM_STRANDS - 1; s >= 0; s--) begin
			if (waiting[s]) begin
				first_waiting = strand_t'(s);
			end
		end
	end

	// Keep the same strand on the port until it is acknowledged
	assign sel_strand = hold_q ? hold_strand_q : first_waiting;
	assign resp_hit = cpi_i.valid && (cpi_i.unit == UNIT_ID);

	always_comb begin
		pci_o = '0;
		pci_o.valid = |waiting;
		pci_o.unit = UNIT_ID;
		pci_o.strand = sel_strand;
		pci_o.op = OP_LOAD;
		pci_o.address = line_q[sel_strand];
	end

	always_ff @(posedge clk) begin
		if (miss_i.valid) begin
			line_q[miss_i.strand] <= miss_i.addr.ln.line;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pending_q <= '0;
			issued_q <= '0;
			hold_q <= 1'b0;
			hold_strand_q <= '0;
			load_complete_o <= '0;
		end else begin
			load_complete_o <= '0;

			if (pci_o.valid && pci_ack_i) begin
				issued_q[sel_strand] <= 1'b1;
				hold_q <= 1'b0;
			end else if (pci_o.valid) begin
				hold_q <= 1'b1;
				hold_strand_q <= sel_strand;
			end

			if (resp_hit) begin
				pending_q[cpi_i.strand] <= 1'b0;
				issued_q[cpi_i.strand] <= 1'b0;
				load_complete_o[cpi_i.strand] <= 1'b1;
			end

			// New miss last, it owns the entry from here on
			if (miss_i.valid) begin
				pending_q[miss_i.strand] <= 1'b1;
				issued_q[miss_i.strand] <= 1'b0;
			end
		end
	end

endmodule

// File: hw/l2_pkg.sv
/*
 * L2 request and response formats.
 * Requests are held until acknowledged; responses have no back-pressure.
 * A response is meant for the requester whose unit it carries.
 */

package l2_pkg;

	typedef enum logic [1:0] {
		UNIT_ICACHE = 2'd0,
		UNIT_DCACHE = 2'd1,
		UNIT_STBUF = 2'd2
	} l2_unit_t;

	typedef enum logic [2:0] {
		OP_LOAD = 3'd0,
		OP_STORE = 3'd1
	} l2_op_t;

	localparam int NUM_REQUESTERS = 3;

	typedef struct packed {
		logic valid;
		l2_unit_t unit;
		core_pkg::strand_t strand;
		l2_op_t op;
		logic [core_pkg::LINE_ADDR_W-1:0] address;
		core_pkg::line_data_t data;
		core_pkg::line_mask_t mask;
	} l2_req_t;

	// Status is passed through, no unit acts on it yet
	typedef struct packed {
		logic valid;
		logic status;
		l2_unit_t unit;
		core_pkg::strand_t strand;
		core_pkg::line_data_t data;
	} l2_resp_t;

endpackage

// File: hw/core_pkg.sv
/*
 * Core geometry shared by the miss queues and the store buffer.
 * Four strands and 16-byte lines. Mask bit b enables data bits [8b+7:8b].
 * The byte address is read either as tag/set/offset or as line/offset.
 */

package core_pkg;

	localparam int NUM_STRANDS = 4;
	localparam int LINE_BYTES = 16;
	localparam int OFFSET_W = $clog2(LINE_BYTES);
	localparam int SET_W = 5;
	localparam int TAG_W = 32 - SET_W - OFFSET_W;
	localparam int LINE_ADDR_W = 32 - OFFSET_W;

	typedef logic [$clog2(NUM_STRANDS)-1:0] strand_t;
	typedef logic [LINE_BYTES*8-1:0] line_data_t;
	typedef logic [LINE_BYTES-1:0] line_mask_t;

	// L1 view, used for the store buffer compare
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [SET_W-1:0] set;
		logic [OFFSET_W-1:0] offset;
	} l1_tso_t;

	// L2 view, the offset is dropped on requests
	typedef struct packed {
		logic [LINE_ADDR_W-1:0] line;
		logic [OFFSET_W-1:0] offset;
	} l1_line_t;

	typedef union packed {
		l1_tso_t tso;
		l1_line_t ln;
	} l1_addr_u;

	typedef struct packed {
		logic valid;
		strand_t strand;
		l1_addr_u addr;
	} miss_req_t;

	typedef struct packed {
		logic valid;
		strand_t strand;
		l1_addr_u addr;
		line_data_t data;
		line_mask_t mask;
	} store_req_t;

endpackage
